//--- g729_ops_pkg.sv
`default_nettype none

package g729_ops_pkg;

	//////////////////////////////////////////////////
	// Basic operation select
	//////////////////////////////////////////////////
	typedef enum logic [2:0]
	{
		L_MULT    = 3'd0,
		L_MAC     = 3'd1,
		L_MSU     = 3'd2,
		L_ADD     = 3'd3,
		L_SUB     = 3'd4,
		L_SHL1    = 3'd5,
		L_SHR_R13 = 3'd6,
		MULT      = 3'd7
	} basic_op_e;

	//////////////////////////////////////////////////
	// Saturation bounds
	//////////////////////////////////////////////////
	localparam logic signed [31:0] MAX_32 = 32'sh7fff_ffff;
	localparam logic signed [31:0] MIN_32 = 32'sh8000_0000;
	localparam logic signed [15:0] MAX_16 = 16'sh7fff;
	localparam logic signed [15:0] MIN_16 = 16'sh8000;

	// Polynomial seed, 1.0 in Q24
	localparam logic signed [31:0] ONE_Q24 = 32'sd16777216;

	// a[0] is always 1.0 in Q12
	localparam logic signed [15:0] A0_Q12 = 16'sd4096;

endpackage

`default_nettype wire

//--- scratch_map_pkg.sv
`default_nettype none

package scratch_map_pkg;

	// Data bus width of every Wishbone port
	localparam int WORD_W = 32;

	localparam int LSP_COUNT = 10;
	localparam int AZ_COUNT  = 11;

	// Conversion engine sequence
	typedef enum logic [2:0]
	{
		IDLE      = 3'd0,
		READ_LSP  = 3'd1,
		POLY_INIT = 3'd2,
		POLY_STEP = 3'd3,
		POLY_SUM  = 3'd4,
		WRITE_AZ  = 3'd5,
		DONE      = 3'd6
	} engine_state_e;

endpackage

`default_nettype wire

//--- basic_op_alu.sv
`timescale 1ns/1ps
`default_nettype none

module basic_op_alu
(
	input  wire g729_ops_pkg::basic_op_e i_op,
	input  wire logic signed [31:0]      i_var1,
	input  wire logic signed [15:0]      i_var2,
	input  wire logic signed [31:0]      i_acc,
	output logic signed [31:0]           o_result
);

	import g729_ops_pkg::*;

	logic signed [31:0] product;
	logic signed [31:0] l_mult_res;
	logic signed [15:0] mult_res;
	logic signed [32:0] wide_sum;

	// Clamp a 33-bit intermediate into 32 bits
	function automatic logic signed [31:0] sat32(input logic signed [32:0] x);
		logic signed [31:0] r;
		if (x > 33'sd2147483647)
		begin
			r = MAX_32;
		end
		else if (x < -33'sd2147483648)
		begin
			r = MIN_32;
		end
		else
		begin
			r = x[31:0];
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Shared multiplier
	//////////////////////////////////////////////////
	always_comb
	begin
		product = $signed(i_var1[15:0]) * i_var2;

		// Only -32768 * -32768 overflows once doubled
		if (product == 32'sh4000_0000)
		begin
			l_mult_res = MAX_32;
			mult_res   = MAX_16;
		end
		else
		begin
			l_mult_res = product <<< 1;
			mult_res   = 16'(product >>> 15);
		end
	end

	//////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////
	always_comb
	begin
		wide_sum = '0;
		o_result = '0;
		case (i_op)
			L_MULT:
				o_result = l_mult_res;
			L_MAC:
			begin
				wide_sum = 33'(i_acc) + 33'(l_mult_res);
				o_result = sat32(wide_sum);
			end
			L_MSU:
			begin
				wide_sum = 33'(i_acc) - 33'(l_mult_res);
				o_result = sat32(wide_sum);
			end
			L_ADD:
			begin
				wide_sum = 33'(i_acc) + 33'(i_var1);
				o_result = sat32(wide_sum);
			end
			L_SUB:
			begin
				wide_sum = 33'(i_acc) - 33'(i_var1);
				o_result = sat32(wide_sum);
			end
			L_SHL1:
			begin
				wide_sum = 33'(i_var1) <<< 1;
				o_result = sat32(wide_sum);
			end
			L_SHR_R13:
				// Round on the last bit shifted out
				o_result = (i_var1 >>> 13) + (i_var1[12] ? 32'sd1 : 32'sd0);
			MULT:
				o_result = 32'(mult_res);
			default:
				o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- lsp_to_az.sv
`timescale 1ns/1ps
`default_nettype none

module lsp_to_az
#(
	parameter int ADDR_W = 12
)
(
	input  wire logic                                i_clock,
	input  wire logic                                i_arst_n,
	input  wire logic                                i_start,
	input  wire logic [ADDR_W-1:0]                   i_lsp_addr,
	input  wire logic [ADDR_W-1:0]                   i_az_addr,
	output logic                                     o_done,
	output logic                                     o_cyc,
	output logic                                     o_stb,
	output logic                                     o_we,
	output logic [ADDR_W-1:0]                        o_adr,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_dat_w,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_dat_r,
	input  wire logic                                i_ack
);

	import g729_ops_pkg::*;
	import scratch_map_pkg::*;

	engine_state_e state;
	logic [3:0] k;
	logic [2:0] i;
	logic [2:0] j;
	logic pol;

	logic [ADDR_W-1:0] lsp_base;
	logic [ADDR_W-1:0] az_base;
	logic signed [15:0] lsp_r [LSP_COUNT];

	// f1 in row 0, f2 in row 1
	logic signed [31:0] f_reg [2][6];

	logic [3:0] lsp_idx;
	logic signed [15:0] lsp_cur;
	logic [2:0] j_m1;
	logic [2:0] j_m2;
	logic [3:0] m;
	logic signed [15:0] hi;
	logic signed [15:0] lo;

	logic signed [31:0] hi_res, lo_res, mac_res, shl_res, msu_res;
	logic signed [31:0] add_a, add_b, sub_a, sub_b, add_res, sub_res;
	logic signed [31:0] rnd_in, rnd_res;

	//////////////////////////////////////////////////
	// Operand selection
	//////////////////////////////////////////////////
	// Even LSPs feed f1, odd LSPs feed f2
	assign lsp_idx = (state == POLY_INIT) ? {3'd0, pol} : {i - 3'd1, pol};
	assign lsp_cur = lsp_r[lsp_idx];
	assign j_m1 = (j >= 3'd1) ? j - 3'd1 : 3'd0;
	assign j_m2 = (j >= 3'd2) ? j - 3'd2 : 3'd0;
	assign m = (k <= 4'd5) ? k : 4'd11 - k;

	// L_Extract of f[j-1]
	assign hi = f_reg[pol][j_m1][31:16];
	assign lo = {1'b0, f_reg[pol][j_m1][15:1]};

	always_comb
	begin
		case (state)
			POLY_SUM:
			begin
				add_a = f_reg[0][k[2:0]];
				add_b = f_reg[0][k[2:0] - 3'd1];
				sub_a = f_reg[1][k[2:0]];
				sub_b = f_reg[1][k[2:0] - 3'd1];
			end
			WRITE_AZ:
			begin
				add_a = f_reg[0][m[2:0]];
				add_b = f_reg[1][m[2:0]];
				sub_a = f_reg[0][m[2:0]];
				sub_b = f_reg[1][m[2:0]];
			end
			default:
			begin
				add_a = f_reg[pol][j];
				add_b = f_reg[pol][j_m2];
				sub_a = add_res;
				sub_b = shl_res;
			end
		endcase
	end

	// a[1..5] from sums, a[6..10] from differences
	assign rnd_in = (k <= 4'd5) ? add_res : sub_res;

	//////////////////////////////////////////////////
	// Arithmetic
	//////////////////////////////////////////////////
	basic_op_alu u_hi (.i_op(L_MULT), .i_var1(32'(hi)), .i_var2(lsp_cur),
		.i_acc(32'sd0), .o_result(hi_res));
	basic_op_alu u_lo (.i_op(MULT), .i_var1(32'(lo)), .i_var2(lsp_cur),
		.i_acc(32'sd0), .o_result(lo_res));
	basic_op_alu u_mac (.i_op(L_MAC), .i_var1(lo_res), .i_var2(16'sd1),
		.i_acc(hi_res), .o_result(mac_res));
	basic_op_alu u_shl (.i_op(L_SHL1), .i_var1(mac_res), .i_var2(16'sd0),
		.i_acc(32'sd0), .o_result(shl_res));
	basic_op_alu u_add (.i_op(L_ADD), .i_var1(add_b), .i_var2(16'sd0),
		.i_acc(add_a), .o_result(add_res));
	basic_op_alu u_sub (.i_op(L_SUB), .i_var1(sub_b), .i_var2(16'sd0),
		.i_acc(sub_a), .o_result(sub_res));
	basic_op_alu u_msu (.i_op(L_MSU), .i_var1(32'(lsp_cur)), .i_var2(16'sd512),
		.i_acc((state == POLY_INIT) ? 32'sd0 : f_reg[pol][1]), .o_result(msu_res));
	basic_op_alu u_rnd (.i_op(L_SHR_R13), .i_var1(rnd_in), .i_var2(16'sd0),
		.i_acc(32'sd0), .o_result(rnd_res));

	//////////////////////////////////////////////////
	// Bus outputs
	//////////////////////////////////////////////////
	assign o_done = (state == DONE);
	assign o_we = (state == WRITE_AZ);
	assign o_adr = (state == WRITE_AZ) ? az_base + ADDR_W'(k) : lsp_base + ADDR_W'(k);
	assign o_dat_w = (state != WRITE_AZ) ? '0 :
		(k == 4'd0) ? WORD_W'(A0_Q12) : {{(WORD_W - 16){rnd_res[15]}}, rnd_res[15:0]};

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state <= IDLE;
			o_cyc <= 1'b0;
			o_stb <= 1'b0;
			k <= '0;
			i <= '0;
			j <= '0;
			pol <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (i_start)
					begin
						k <= '0;
						pol <= 1'b0;
						state <= READ_LSP;
					end
				READ_LSP, WRITE_AZ:
					if (i_ack)
					begin
						o_cyc <= 1'b0;
						o_stb <= 1'b0;
						if (state == READ_LSP && k == 4'(LSP_COUNT - 1))
						begin
							state <= POLY_INIT;
						end
						else if (state == WRITE_AZ && k == 4'(AZ_COUNT - 1))
						begin
							state <= DONE;
						end
						else
						begin
							k <= k + 4'd1;
						end
					end
					else if (!o_cyc)
					begin
						o_cyc <= 1'b1;
						o_stb <= 1'b1;
					end
				POLY_INIT:
				begin
					i <= 3'd2;
					j <= 3'd2;
					state <= POLY_STEP;
				end
				POLY_STEP:
					if (j == 3'd1)
					begin
						if (i != 3'd5)
						begin
							i <= i + 3'd1;
							j <= i + 3'd1;
						end
						else if (!pol)
						begin
							pol <= 1'b1;
							state <= POLY_INIT;
						end
						else
						begin
							k <= 4'd5;
							state <= POLY_SUM;
						end
					end
					else
					begin
						j <= j - 3'd1;
					end
				POLY_SUM:
					if (k == 4'd1)
					begin
						k <= '0;
						state <= WRITE_AZ;
					end
					else
					begin
						k <= k - 4'd1;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Register file and captured inputs
	//////////////////////////////////////////////////
	always_ff @(posedge i_clock)
	begin
		case (state)
			IDLE:
				if (i_start)
				begin
					lsp_base <= i_lsp_addr;
					az_base <= i_az_addr;
				end
			READ_LSP:
				if (i_ack)
				begin
					lsp_r[k] <= i_dat_r[15:0];
				end
			POLY_INIT:
			begin
				f_reg[pol][0] <= ONE_Q24;
				f_reg[pol][1] <= msu_res;
				f_reg[pol][2] <= ONE_Q24;
			end
			POLY_STEP:
				if (j == 3'd1)
				begin
					f_reg[pol][1] <= msu_res;
					// Next order starts as a copy of the updated f[i-1]
					if (i != 3'd5)
					begin
						f_reg[pol][i + 3'd1] <= (i == 3'd2) ? msu_res : f_reg[pol][i - 3'd1];
					end
				end
				else
				begin
					f_reg[pol][j] <= sub_res;
				end
			POLY_SUM:
			begin
				f_reg[0][k[2:0]] <= add_res;
				f_reg[1][k[2:0]] <= sub_res;
			end
			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- scratch_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_arbiter
#(
	parameter int ADDR_W = 12
)
(
	input  wire logic                                i_clock,
	input  wire logic                                i_arst_n,

	input  wire logic                                i_h_cyc,
	input  wire logic                                i_h_stb,
	input  wire logic                                i_h_we,
	input  wire logic [ADDR_W-1:0]                   i_h_adr,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_h_dat_w,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_h_dat_r,
	output logic                                     o_h_ack,

	input  wire logic                                i_e_cyc,
	input  wire logic                                i_e_stb,
	input  wire logic                                i_e_we,
	input  wire logic [ADDR_W-1:0]                   i_e_adr,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_e_dat_w,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_e_dat_r,
	output logic                                     o_e_ack,

	output logic                                     o_m_cyc,
	output logic                                     o_m_stb,
	output logic                                     o_m_we,
	output logic [ADDR_W-1:0]                        o_m_adr,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_m_dat_w,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_m_dat_r,
	input  wire logic                                i_m_ack
);

	logic owner_valid;
	logic owner_host;
	logic keep_h;
	logic keep_e;
	logic sel_host;

	// Current owner keeps the bus while cyc is high
	assign keep_h = owner_valid & owner_host & i_h_cyc;
	assign keep_e = owner_valid & ~owner_host & i_e_cyc;

	// Free bus goes to the engine first
	assign sel_host = keep_h | (~keep_e & ~i_e_cyc & i_h_cyc);

	assign o_m_cyc   = sel_host ? i_h_cyc   : i_e_cyc;
	assign o_m_stb   = sel_host ? i_h_stb   : i_e_stb;
	assign o_m_we    = sel_host ? i_h_we    : i_e_we;
	assign o_m_adr   = sel_host ? i_h_adr   : i_e_adr;
	assign o_m_dat_w = sel_host ? i_h_dat_w : i_e_dat_w;

	assign o_h_dat_r = i_m_dat_r;
	assign o_e_dat_r = i_m_dat_r;
	assign o_h_ack = i_m_ack & sel_host;
	assign o_e_ack = i_m_ack & ~sel_host;

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			owner_valid <= 1'b0;
			owner_host <= 1'b0;
		end
		else
		begin
			owner_valid <= o_m_cyc;
			owner_host <= sel_host;
		end
	end

endmodule

`default_nettype wire

//--- scratch_memory.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_memory
#(
	parameter int ADDR_W    = 12,
	parameter int MEM_DEPTH = 4096
)
(
	input  wire logic                                i_clock,
	input  wire logic                                i_arst_n,
	input  wire logic                                i_cyc,
	input  wire logic                                i_stb,
	input  wire logic                                i_we,
	input  wire logic [ADDR_W-1:0]                   i_adr,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_dat_w,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_dat_r,
	output logic                                     o_ack
);

	import scratch_map_pkg::*;

	logic [WORD_W-1:0] mem [MEM_DEPTH];
	logic access;

	// New request only when no ack is outstanding
	assign access = i_cyc & i_stb & ~o_ack;

	always_ff @(posedge i_clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_ack <= 1'b0;
		end
		else
		begin
			o_ack <= access;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (access)
		begin
			if (i_we)
			begin
				mem[i_adr] <= i_dat_w;
			end
			o_dat_r <= mem[i_adr];
		end
	end

endmodule

`default_nettype wire

//--- lsp_to_az_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lsp_to_az_pipe
#(
	parameter int ADDR_W    = 12,
	parameter int MEM_DEPTH = 4096
)
(
	input  wire logic                                i_clock,
	input  wire logic                                i_arst_n,
	input  wire logic                                i_start,
	input  wire logic [ADDR_W-1:0]                   i_lsp_addr,
	input  wire logic [ADDR_W-1:0]                   i_az_addr,
	output logic                                     o_done,
	input  wire logic                                i_host_cyc,
	input  wire logic                                i_host_stb,
	input  wire logic                                i_host_we,
	input  wire logic [ADDR_W-1:0]                   i_host_adr,
	input  wire logic [scratch_map_pkg::WORD_W-1:0]  i_host_dat_w,
	output logic [scratch_map_pkg::WORD_W-1:0]       o_host_dat_r,
	output logic                                     o_host_ack
);

	import scratch_map_pkg::*;

	//////////////////////////////////////////////////
	// Engine and memory buses
	//////////////////////////////////////////////////
	logic e_cyc, e_stb, e_we, e_ack;
	logic [ADDR_W-1:0] e_adr;
	logic [WORD_W-1:0] e_dat_w, e_dat_r;

	logic m_cyc, m_stb, m_we, m_ack;
	logic [ADDR_W-1:0] m_adr;
	logic [WORD_W-1:0] m_dat_w, m_dat_r;

	lsp_to_az #(.ADDR_W(ADDR_W)) u_engine
	(
		.i_clock(i_clock), .i_arst_n(i_arst_n), .i_start(i_start),
		.i_lsp_addr(i_lsp_addr), .i_az_addr(i_az_addr), .o_done(o_done),
		.o_cyc(e_cyc), .o_stb(e_stb), .o_we(e_we), .o_adr(e_adr),
		.o_dat_w(e_dat_w), .i_dat_r(e_dat_r), .i_ack(e_ack)
	);

	scratch_arbiter #(.ADDR_W(ADDR_W)) u_arbiter
	(
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_h_cyc(i_host_cyc), .i_h_stb(i_host_stb), .i_h_we(i_host_we),
		.i_h_adr(i_host_adr), .i_h_dat_w(i_host_dat_w),
		.o_h_dat_r(o_host_dat_r), .o_h_ack(o_host_ack),
		.i_e_cyc(e_cyc), .i_e_stb(e_stb), .i_e_we(e_we), .i_e_adr(e_adr),
		.i_e_dat_w(e_dat_w), .o_e_dat_r(e_dat_r), .o_e_ack(e_ack),
		.o_m_cyc(m_cyc), .o_m_stb(m_stb), .o_m_we(m_we), .o_m_adr(m_adr),
		.o_m_dat_w(m_dat_w), .i_m_dat_r(m_dat_r), .i_m_ack(m_ack)
	);

	scratch_memory #(.ADDR_W(ADDR_W), .MEM_DEPTH(MEM_DEPTH)) u_memory
	(
		.i_clock(i_clock), .i_arst_n(i_arst_n),
		.i_cyc(m_cyc), .i_stb(m_stb), .i_we(m_we), .i_adr(m_adr),
		.i_dat_w(m_dat_w), .o_dat_r(m_dat_r), .o_ack(m_ack)
	);

endmodule

`default_nettype wire

//--- tb_lsp_to_az_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsp_to_az_pipe;

	import g729_ops_pkg::*;
	import scratch_map_pkg::*;

	localparam int ADDR_W        = 12;
	localparam int MEM_DEPTH     = 4096;
	localparam int ENTRIES       = 8;
	localparam int FIXED_ENTRIES = 3;
	localparam int ACK_TIMEOUT   = 64;
	localparam int DONE_TIMEOUT  = 2000;
	localparam int unsigned SEED = 66702;

	logic clock;
	logic arst_n;
	logic start;
	logic [ADDR_W-1:0] lsp_addr;
	logic [ADDR_W-1:0] az_addr;
	logic done;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	logic [ADDR_W-1:0] host_adr;
	logic [WORD_W-1:0] host_dat_w;
	logic [WORD_W-1:0] host_dat_r;
	logic host_ack;

	// Stimulus table, one row per conversion
	shortint tbl_lsp [ENTRIES][LSP_COUNT];
	logic [ADDR_W-1:0] tbl_lsp_addr [ENTRIES];
	logic [ADDR_W-1:0] tbl_az_addr [ENTRIES];
	logic [WORD_W-1:0] tbl_az [ENTRIES][AZ_COUNT];

	// Reference model scratch
	shortint model_lsp [LSP_COUNT];
	int poly [2][6];

	int unsigned rng_state;
	int err_count;
	int errs_at_start;
	int test_count;
	int failed_tests;

	lsp_to_az_pipe #(.ADDR_W(ADDR_W), .MEM_DEPTH(MEM_DEPTH)) UUT
	(
		.i_clock(clock), .i_arst_n(arst_n), .i_start(start),
		.i_lsp_addr(lsp_addr), .i_az_addr(az_addr), .o_done(done),
		.i_host_cyc(host_cyc), .i_host_stb(host_stb), .i_host_we(host_we),
		.i_host_adr(host_adr), .i_host_dat_w(host_dat_w),
		.o_host_dat_r(host_dat_r), .o_host_ack(host_ack)
	);

	always #4 clock = ~clock;

	//////////////////////////////////////////////////
	// Fixed-point reference operations
	//////////////////////////////////////////////////
	function automatic int sat32(input longint x);
		if (x > longint'(MAX_32))
			return MAX_32;
		if (x < longint'(MIN_32))
			return MIN_32;
		return int'(x);
	endfunction

	function automatic int ref_l_mult(input shortint a, input shortint b);
		if (a == MIN_16 && b == MIN_16)
			return MAX_32;
		return int'(a) * int'(b) * 2;
	endfunction

	function automatic shortint ref_mult(input shortint a, input shortint b);
		int p;
		p = (int'(a) * int'(b)) >>> 15;
		if (p > int'(MAX_16))
			return MAX_16;
		return shortint'(p);
	endfunction

	function automatic int ref_l_add(input int a, input int b);
		return sat32(longint'(a) + longint'(b));
	endfunction

	function automatic int ref_l_sub(input int a, input int b);
		return sat32(longint'(a) - longint'(b));
	endfunction

	function automatic int ref_l_mac(input int acc, input shortint a, input shortint b);
		return ref_l_add(acc, ref_l_mult(a, b));
	endfunction

	function automatic int ref_l_msu(input int acc, input shortint a, input shortint b);
		return ref_l_sub(acc, ref_l_mult(a, b));
	endfunction

	function automatic int ref_shr_r13(input int x);
		return (x >>> 13) + ((x >>> 12) & 1);
	endfunction

	function automatic int ref_mpy_32_16(input shortint hi, input shortint lo, input shortint n);
		return ref_l_mac(ref_l_mult(hi, n), ref_mult(lo, n), 16'sd1);
	endfunction

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Address in every field, so aliasing shows up
	function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] adr);
		return {4'hA, adr, 4'h5, ~adr};
	endfunction

	//////////////////////////////////////////////////
	// Lsp_Az model
	//////////////////////////////////////////////////
	// p = 0 builds f1 from even LSPs, p = 1 builds f2 from odd LSPs
	task automatic build_poly(input int p);
		int i;
		int j;
		int t0;
		shortint hi;
		shortint lo;
		shortint ls;
		poly[p][0] = ONE_Q24;
		poly[p][1] = ref_l_msu(0, model_lsp[p], 16'sd512);
		for (i = 2; i <= 5; i++)
		begin
			ls = model_lsp[2 * i - 2 + p];
			poly[p][i] = poly[p][i - 2];
			for (j = i; j >= 2; j--)
			begin
				hi = shortint'(poly[p][j - 1] >>> 16);
				lo = shortint'(ref_l_msu(poly[p][j - 1] >>> 1, hi, 16'sd16384));
				t0 = sat32(longint'(ref_mpy_32_16(hi, lo, ls)) * 2);
				poly[p][j] = ref_l_add(poly[p][j], poly[p][j - 2]);
				poly[p][j] = ref_l_sub(poly[p][j], t0);
			end
			poly[p][1] = ref_l_msu(poly[p][1], ls, 16'sd512);
		end
	endtask

	task automatic compute_az(input int e);
		int i;
		int t0;
		for (i = 0; i < LSP_COUNT; i++)
			model_lsp[i] = tbl_lsp[e][i];
		build_poly(0);
		build_poly(1);
		for (i = 5; i > 0; i--)
		begin
			poly[0][i] = ref_l_add(poly[0][i], poly[0][i - 1]);
			poly[1][i] = ref_l_sub(poly[1][i], poly[1][i - 1]);
		end
		tbl_az[e][0] = int'(A0_Q12);
		for (i = 1; i <= 5; i++)
		begin
			t0 = ref_l_add(poly[0][i], poly[1][i]);
			tbl_az[e][i] = int'(shortint'(ref_shr_r13(t0)));
			t0 = ref_l_sub(poly[0][i], poly[1][i]);
			tbl_az[e][AZ_COUNT - i] = int'(shortint'(ref_shr_r13(t0)));
		end
	endtask

	task automatic build_table();
		int e;
		int k;
		int n;
		shortint t;
		for (e = 0; e < ENTRIES; e++)
		begin
			tbl_lsp_addr[e] = ADDR_W'(12'h100 + 16 * e);
			tbl_az_addr[e] = ADDR_W'(12'h400 + 16 * e);
			for (k = 0; k < LSP_COUNT; k++)
			begin
				case (e)
					0: tbl_lsp[e][k] = shortint'(30000 - 6000 * k);
					1: tbl_lsp[e][k] = MAX_16;
					2: tbl_lsp[e][k] = MIN_16;
					default:
					begin
						rng_state = lcg_next(rng_state);
						tbl_lsp[e][k] = shortint'(rng_state[30:15]);
					end
				endcase
			end
			// Cosine domain, so descending order
			if (e >= FIXED_ENTRIES)
			begin
				for (n = LSP_COUNT - 1; n > 0; n--)
					for (k = 0; k < n; k++)
						if (tbl_lsp[e][k] < tbl_lsp[e][k + 1])
						begin
							t = tbl_lsp[e][k];
							tbl_lsp[e][k] = tbl_lsp[e][k + 1];
							tbl_lsp[e][k + 1] = t;
						end
			end
			compute_az(e);
		end
	endtask

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////
	task automatic check_value(input string signal, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH at %0t ns: %s expected 0x%h, got 0x%h",
				$time, signal, expected, actual);
			err_count++;
		end
	endtask

	task automatic begin_test();
		errs_at_start = err_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == errs_at_start)
			$display("[%0t ns] test %0d, %s: ok", $time, test_count, name);
		else
		begin
			failed_tests++;
			$display("[%0t ns] test %0d, %s: FAILED with %0d errors",
				$time, test_count, name, err_count - errs_at_start);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Tests run: %0d, failed: %0d, failed checks: %0d",
			test_count, failed_tests + 1, err_count);
		$display("Test failures found");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Host bus and engine control
	//////////////////////////////////////////////////
	task automatic wait_host_ack(input string what, input logic [ADDR_W-1:0] adr);
		int cycles;
		logic acked;
		cycles = 0;
		acked = 1'b0;
		while (!acked && cycles < ACK_TIMEOUT)
		begin
			@(posedge clock);
			#1;
			acked = (host_ack === 1'b1);
			cycles++;
		end
		if (!acked)
			abort_run($sformatf("Timeout at %0t ns: host %s at 0x%h got no ack in %0d cycles",
				$time, what, adr, ACK_TIMEOUT));
	endtask

	task automatic host_write(input logic [ADDR_W-1:0] adr, input logic [WORD_W-1:0] data);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = 1'b1;
		host_adr = adr;
		host_dat_w = data;
		wait_host_ack("write", adr);
		// Hold through the ack cycle
		@(posedge clock);
		#1;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic host_read(input logic [ADDR_W-1:0] adr, output logic [WORD_W-1:0] data);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = 1'b0;
		host_adr = adr;
		wait_host_ack("read", adr);
		data = host_dat_r;
		@(posedge clock);
		#1;
		host_cyc = 1'b0;
		host_stb = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < DONE_TIMEOUT)
		begin
			@(posedge clock);
			#1;
			seen = (done === 1'b1);
			cycles++;
		end
		if (!seen)
			abort_run($sformatf("Timeout at %0t ns: o_done did not pulse within %0d cycles",
				$time, DONE_TIMEOUT));
	endtask

	task automatic run_entry(input int e);
		int k;
		logic [ADDR_W-1:0] side_adr;
		logic [ADDR_W-1:0] guard_lo;
		logic [ADDR_W-1:0] adr;
		logic [WORD_W-1:0] side_data;
		logic [WORD_W-1:0] rd;
		side_adr = ADDR_W'(12'h800 + e);
		guard_lo = tbl_az_addr[e] - 1'b1;
		// Guard word below, Az words, sentinel above
		for (k = 0; k < AZ_COUNT + 2; k++)
			host_write(guard_lo + ADDR_W'(k), fill_word(guard_lo + ADDR_W'(k)));
		for (k = 0; k < LSP_COUNT; k++)
			host_write(tbl_lsp_addr[e] + ADDR_W'(k), int'(tbl_lsp[e][k]));
		host_write(side_adr, fill_word(side_adr));

		lsp_addr = tbl_lsp_addr[e];
		az_addr = tbl_az_addr[e];
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;

		// Host access competes with the running engine
		fork
			host_read(side_adr, side_data);
			wait_done();
		join
		check_value($sformatf("o_host_dat_r (side word 0x%h)", side_adr),
			fill_word(side_adr), side_data);

		for (k = 0; k < AZ_COUNT; k++)
		begin
			adr = tbl_az_addr[e] + ADDR_W'(k);
			host_read(adr, rd);
			check_value($sformatf("o_host_dat_r (a[%0d] at 0x%h)", k, adr), tbl_az[e][k], rd);
		end
		host_read(guard_lo, rd);
		check_value("o_host_dat_r (guard below Az)", fill_word(guard_lo), rd);
		adr = tbl_az_addr[e] + ADDR_W'(AZ_COUNT);
		host_read(adr, rd);
		check_value("o_host_dat_r (sentinel above Az)", fill_word(adr), rd);
		for (k = 0; k < LSP_COUNT; k++)
		begin
			adr = tbl_lsp_addr[e] + ADDR_W'(k);
			host_read(adr, rd);
			check_value($sformatf("o_host_dat_r (lsp[%0d] at 0x%h)", k, adr),
				int'(tbl_lsp[e][k]), rd);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int e;
		int k;
		logic [WORD_W-1:0] pattern [8];
		logic [WORD_W-1:0] rd;
		clock = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		lsp_addr = '0;
		az_addr = '0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		err_count = 0;
		test_count = 0;
		failed_tests = 0;
		rng_state = SEED;

		build_table();

		repeat (8) @(posedge clock);
		#1;
		arst_n = 1'b1;

		begin_test();
		check_value("o_done", '0, 32'(done));
		check_value("o_host_ack", '0, 32'(host_ack));
		end_test("outputs after reset");

		begin_test();
		for (k = 0; k < 8; k++)
		begin
			rng_state = lcg_next(rng_state);
			pattern[k] = rng_state;
			host_write(ADDR_W'(12'hC00 + k), pattern[k]);
		end
		for (k = 0; k < 8; k++)
		begin
			host_read(ADDR_W'(12'hC00 + k), rd);
			check_value($sformatf("o_host_dat_r (0x%h)", 12'hC00 + k), pattern[k], rd);
		end
		end_test("host write then readback");

		for (e = 0; e < ENTRIES; e++)
		begin
			begin_test();
			run_entry(e);
			case (e)
				0: end_test("conversion, typical spread");
				1: end_test("conversion, all LSPs 32767");
				2: end_test("conversion, all LSPs -32768");
				default: end_test($sformatf("conversion, random set %0d", e - FIXED_ENTRIES));
			endcase
		end

		$display("Tests run: %0d, failed: %0d, failed checks: %0d",
			test_count, failed_tests, err_count);
		if (failed_tests == 0 && err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
g729_ops_pkg.sv
scratch_map_pkg.sv
basic_op_alu.sv
lsp_to_az.sv
scratch_arbiter.sv
scratch_memory.sv
lsp_to_az_pipe.sv
tb_lsp_to_az_pipe.sv

//--- Bender.yml
package:
  name: lsp_to_az_pipe

sources:
  # Packages first, then the design from the leaves up
  - g729_ops_pkg.sv
  - scratch_map_pkg.sv
  - basic_op_alu.sv
  - lsp_to_az.sv
  - scratch_arbiter.sv
  - scratch_memory.sv
  - lsp_to_az_pipe.sv
  - target: test
    files:
      - tb_lsp_to_az_pipe.sv
